// File: build.f
logic/osd_video_pkg.sv
logic/osd_ctrl_pkg.sv
logic/spi_deserializer.sv
logic/osd_cmd_fsm.sv
logic/video_timing.sv
logic/osd_buffer.sv
logic/osd_mixer.sv
logic/osd_top.sv
tests/tb_clock.sv
tests/osd_tb.sv

// File: Bender.yml
package:
  name: osd_overlay

sources:
  - logic/osd_video_pkg.sv
  - logic/osd_ctrl_pkg.sv
  - logic/spi_deserializer.sv
  - logic/osd_cmd_fsm.sv
  - logic/video_timing.sv
  - logic/osd_buffer.sv
  - logic/osd_mixer.sv
  - logic/osd_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/osd_tb.sv

// File: tests/osd_tb.sv
/* table-driven testbench for the on-screen display
   drives frames and serial commands, checks every pixel of the last frame per test */

`timescale 1ns/1ps

module osd_tb import osd_video_pkg::*, osd_ctrl_pkg::*; ();

	// ********************
	// frame geometry
	// ********************

	localparam int active_px = 400;
	localparam int sync_px = 40;
	localparam int active_lines = 160;
	localparam int sync_lines = 8;
	localparam int line_px = active_px + sync_px;
	localparam int frame_lines = active_lines + sync_lines;
	localparam int frame_cycles = line_px * frame_lines;
	// h_pos trails the input by the two sync registers
	localparam int sync_lag = 2;
	// first input column and line inside the overlay window
	localparam int win_x0 = active_px / 2 + int'(osd_x_offset) - int'(osd_width) / 2 + sync_lag;
	localparam int win_y0 = active_lines / 2 + int'(osd_y_offset) - int'(osd_height) / 2;
	// pclk cycles per sck phase
	localparam int sck_half = 4;
	localparam int n_tests = 9;
	localparam int max_errors_shown = 4;
	// four frame times per test, 10 ns per cycle
	localparam int watchdog_ns = n_tests * 4 * frame_cycles * 10;

	// one table row
	typedef struct packed {
		logic [7:0] cmd;
		logic [11:0] len;
		logic [7:0] seed;
		// 1 selects active-high sync pulses
		logic pol;
		// bits of a dropped byte sent before cs_n rises
		logic [2:0] abort_bits;
		logic exp_en;
	} test_vec_t;

	logic pclk;
	logic ss;
	logic sck;
	logic cs_n;
	logic sdi;
	video_pixel_t video_in;
	video_pixel_t video_out;

	test_vec_t tests [n_tests];
	string test_name [n_tests];

	// model of the bitmap and enable
	logic [7:0] model_mem [0:(2**buf_addr_w)-1];
	logic model_enable;
	logic [31:0] lfsr_state;

	// expected outputs of the last two driven pixels
	video_pixel_t exp_d1, exp_d2;
	logic chk_d1, chk_d2;
	int x_d1, y_d1, x_d2, y_d2;

	string cur_name;
	int test_errors;
	int total_errors;
	int failed_tests;
	int pixel_checks;

	tb_clock clock_inst (
		.pclk (pclk),
		.ss   (ss)
	);

	osd_top osd_top_inst (
		.pclk      (pclk),
		.ss        (ss),
		.sck       (sck),
		.cs_n      (cs_n),
		.sdi       (sdi),
		.video_in  (video_in),
		.video_out (video_out)
	);

	// ********************
	// helpers
	// ********************

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	task automatic draw_bits(input int n, output logic [17:0] val);
		val = '0;
		repeat (n) begin
			val = {val[16:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// payload pattern, every address bit shows up in the byte
	function automatic logic [7:0] payload_byte(input logic [7:0] seed, input logic [10:0] addr);
		return seed ^ addr[7:0] ^ {addr[10:8], 5'b00000};
	endfunction

	// pixel as the display rules say it leaves the overlay
	function automatic video_pixel_t expected_pixel(input video_pixel_t pix, input int x,
			input int y);
		video_pixel_t res;
		int h_rel;
		int v_rel;
		logic [10:0] addr;
		logic b;
		res = pix;
		h_rel = x - win_x0;
		v_rel = y - win_y0;
		if (model_enable && h_rel >= 0 && h_rel < int'(osd_width)
				&& v_rel >= 0 && v_rel < int'(osd_height)) begin
			addr = {v_rel[6:4], h_rel[7:0]};
			// two lines per bitmap bit
			b = model_mem[addr][v_rel[3:1]];
			res.red = {b, b, osd_color[2], pix.red[5:3]};
			res.green = {b, b, osd_color[1], pix.green[5:3]};
			res.blue = {b, b, osd_color[0], pix.blue[5:3]};
		end
		return res;
	endfunction

	task automatic hold(input int n);
		repeat (n) @(negedge pclk);
	endtask

	task automatic set_test(input int idx, input string name, input logic [7:0] cmd,
			input logic [11:0] len, input logic [7:0] seed, input logic pol,
			input logic [2:0] abort_bits, input logic exp_en);
		test_name[idx] = name;
		tests[idx] = {cmd, len, seed, pol, abort_bits, exp_en};
	endtask

	// ********************
	// serial driver
	// ********************

	// msb first, data valid a full phase before sck rises
	task automatic shift_bits(input logic [7:0] data, input int n);
		for (int b = 0; b < n; b++) begin
			sdi = data[7-b];
			hold(sck_half);
			sck = 1'b1;
			hold(sck_half);
			sck = 1'b0;
		end
	endtask

	task automatic send_command(input test_vec_t t);
		logic [10:0] idx;
		logic [10:0] addr;
		logic [7:0] data;
		logic is_write;
		is_write = t.cmd[7:3] == cmd_write;
		cs_n = 1'b0;
		hold(sck_half);
		shift_bits(t.cmd, 8);
		for (int i = 0; i < t.len; i++) begin
			idx = i;
			// row group base, wraps inside the buffer
			addr = {t.cmd[2:0], 8'h00} + idx;
			data = payload_byte(t.seed, is_write ? addr : idx);
			shift_bits(data, 8);
			if (is_write) begin
				model_mem[addr] = data;
			end
		end
		// partial byte, dropped when cs_n rises
		if (t.abort_bits != 0) begin
			shift_bits(8'hff, t.abort_bits);
		end
		hold(sck_half);
		cs_n = 1'b1;
		hold(2 * sck_half);
		if (t.cmd[7:4] == cmd_enable) begin
			model_enable = t.cmd[0];
		end
	endtask

	// ********************
	// video driver and check
	// ********************

	// output seen at this falling edge belongs to the pixel driven two edges back
	task automatic step_pixel(input video_pixel_t pix, input int x, input int y,
			input logic check);
		@(negedge pclk);
		if (chk_d2) begin
			pixel_checks++;
			if (video_out !== exp_d2) begin
				test_errors++;
				if (test_errors <= max_errors_shown) begin
					$display("ERROR %s pixel x=%0d y=%0d expected %h actual %h",
						cur_name, x_d2, y_d2, exp_d2, video_out);
				end
			end
		end
		exp_d2 = exp_d1;
		chk_d2 = chk_d1;
		x_d2 = x_d1;
		y_d2 = y_d1;
		exp_d1 = expected_pixel(pix, x, y);
		chk_d1 = check;
		x_d1 = x;
		y_d1 = y;
		video_in = pix;
	endtask

	task automatic run_frame(input logic pol, input logic check);
		video_pixel_t pix;
		logic [17:0] rgb;
		for (int y = 0; y < frame_lines; y++) begin
			for (int x = 0; x < line_px; x++) begin
				rgb = '0;
				// colour only matters in the checked frame
				if (check) begin
					draw_bits(18, rgb);
				end
				pix.red = rgb[17:12];
				pix.green = rgb[11:6];
				pix.blue = rgb[5:0];
				// sync pulse sits at pol, picture at its inverse
				pix.hs = (x < active_px) ? ~pol : pol;
				pix.vs = (y < active_lines) ? ~pol : pol;
				step_pixel(pix, x, y, check);
			end
		end
	endtask

	// ********************
	// main sequence
	// ********************

	initial begin
		sck = 1'b0;
		cs_n = 1'b1;
		sdi = 1'b0;
		video_in = '0;
		lfsr_state = 32'h81bdf07f;
		model_enable = 1'b0;
		exp_d1 = '0;
		exp_d2 = '0;
		chk_d1 = 1'b0;
		chk_d2 = 1'b0;
		total_errors = 0;
		failed_tests = 0;
		pixel_checks = 0;
		//        name              cmd    len   seed   pol   abort exp_en
		set_test(0, "pass_through", 8'h40, 12'd0, 8'h00, 1'b0, 3'd0, 1'b0);
		set_test(1, "fill_buffer", 8'h20, 12'd2048, 8'h5a, 1'b0, 3'd0, 1'b0);
		set_test(2, "enable_overlay", 8'h41, 12'd0, 8'h00, 1'b0, 3'd0, 1'b1);
		set_test(3, "row_write_g3", 8'h23, 12'd300, 8'hc3, 1'b0, 3'd0, 1'b1);
		set_test(4, "row_write_wrap", 8'h27, 12'd260, 8'h17, 1'b0, 3'd0, 1'b1);
		set_test(5, "inverted_sync", 8'h25, 12'd40, 8'h99, 1'b1, 3'd0, 1'b1);
		// overlay still on, so stray writes would show
		set_test(6, "unknown_cmd", 8'h80, 12'd8, 8'h66, 1'b1, 3'd0, 1'b1);
		set_test(7, "serial_abort", 8'h22, 12'd64, 8'h3c, 1'b1, 3'd5, 1'b1);
		set_test(8, "disable", 8'h40, 12'd0, 8'h00, 1'b0, 3'd0, 1'b0);
		wait (ss === 1'b0);
		@(negedge pclk);
		for (int i = 0; i < n_tests; i++) begin
			cur_name = test_name[i];
			test_errors = 0;
			send_command(tests[i]);
			if (osd_top_inst.osd_enable !== tests[i].exp_en) begin
				test_errors++;
				$display("ERROR %s osd_enable expected %0b actual %0b",
					cur_name, tests[i].exp_en, osd_top_inst.osd_enable);
			end
			// two frames to settle polarity and centres, third one checked
			run_frame(tests[i].pol, 1'b0);
			run_frame(tests[i].pol, 1'b0);
			run_frame(tests[i].pol, 1'b1);
			// drain the last two pixels
			step_pixel(video_in, -1, -1, 1'b0);
			step_pixel(video_in, -1, -1, 1'b0);
			if (test_errors == 0) begin
				$display("test %s ok", cur_name);
			end else begin
				failed_tests++;
				$display("test %s: %0d mismatches", cur_name, test_errors);
			end
			total_errors += test_errors;
		end
		$display("tests %0d, failing tests %0d, pixels compared %0d, mismatches %0d",
			n_tests, failed_tests, pixel_checks, total_errors);
		if (total_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(watchdog_ns);
		$display("run timed out after %0d ns before all tests finished", watchdog_ns);
		$display("Checks failed");
		$finish;
	end

endmodule

// File: tests/tb_clock.sv
/* clock and reset source for the testbench
   10 ns pclk, ss held high for the first 8 cycles */

`timescale 1ns/1ps

module tb_clock (
	output logic pclk,
	output logic ss
);

	localparam int half_period = 5;
	localparam int reset_cycles = 8;

	initial begin
		pclk = 1'b0;
		forever #half_period pclk = ~pclk;
	end

	initial begin
		ss = 1'b1;
		repeat (reset_cycles) @(posedge pclk);
		// release away from the sampling edge
		@(negedge pclk);
		ss = 1'b0;
	end

endmodule

// File: logic/osd_top.sv
/* on-screen display top level, placed between core video and connector
   host loads the bitmap and toggles the overlay over the serial link */

`timescale 1ns/1ps

module osd_top import osd_video_pkg::*, osd_ctrl_pkg::*; (
	input  logic         pclk,
	input  logic         ss,
	input  logic         sck,
	input  logic         cs_n,
	input  logic         sdi,
	input  video_pixel_t video_in,
	output video_pixel_t video_out
);

	// serial to command
	spi_byte_t rx_byte;
	logic byte_valid;

	// command to buffer and mixer
	osd_write_t wr;
	logic write_valid;
	logic osd_enable;

	// timing to mixer
	logic [pos_w-1:0] h_pos, v_pos;
	logic [pos_w-1:0] h_centre, v_centre;
	logic h_active, v_active;

	// mixer to buffer and back
	logic [buf_addr_w-1:0] read_addr;
	logic [7:0] read_data;

	// ********************
	// control path
	// ********************

	spi_deserializer spi_deserializer_inst (
		.pclk       (pclk),
		.ss         (ss),
		.sck        (sck),
		.cs_n       (cs_n),
		.sdi        (sdi),
		.rx_byte    (rx_byte),
		.byte_valid (byte_valid)
	);

	osd_cmd_fsm osd_cmd_fsm_inst (
		.pclk        (pclk),
		.ss          (ss),
		.rx_byte     (rx_byte),
		.byte_valid  (byte_valid),
		.wr          (wr),
		.write_valid (write_valid),
		.osd_enable  (osd_enable)
	);

	osd_buffer osd_buffer_inst (
		.pclk        (pclk),
		.wr          (wr),
		.write_valid (write_valid),
		.read_addr   (read_addr),
		.read_data   (read_data)
	);

	// ********************
	// video path
	// ********************

	video_timing video_timing_inst (
		.pclk     (pclk),
		.ss       (ss),
		.video_in (video_in),
		.h_pos    (h_pos),
		.v_pos    (v_pos),
		.h_centre (h_centre),
		.v_centre (v_centre),
		.h_active (h_active),
		.v_active (v_active)
	);

	osd_mixer osd_mixer_inst (
		.pclk       (pclk),
		.ss         (ss),
		.video_in   (video_in),
		.h_pos      (h_pos),
		.v_pos      (v_pos),
		.h_centre   (h_centre),
		.v_centre   (v_centre),
		.h_active   (h_active),
		.v_active   (v_active),
		.osd_enable (osd_enable),
		.read_addr  (read_addr),
		.read_data  (read_data),
		.video_out  (video_out)
	);

endmodule

// File: logic/osd_mixer.sv
/* overlay mixer with a fixed two cycle video delay
   finds the centred window, fetches the bitmap byte and tints the pixel */

`timescale 1ns/1ps

module osd_mixer import osd_video_pkg::*, osd_ctrl_pkg::*; (
	input  logic                  pclk,
	input  logic                  ss,
	input  video_pixel_t          video_in,
	input  logic [pos_w-1:0]      h_pos,
	input  logic [pos_w-1:0]      v_pos,
	input  logic [pos_w-1:0]      h_centre,
	input  logic [pos_w-1:0]      v_centre,
	input  logic                  h_active,
	input  logic                  v_active,
	input  logic                  osd_enable,
	output logic [buf_addr_w-1:0] read_addr,
	input  logic [7:0]            read_data,
	output video_pixel_t          video_out
);

	logic [pos_w-1:0] h_start, v_start;
	logic [pos_w-1:0] h_rel, v_rel;
	logic in_window;

	// stage one registers
	video_pixel_t video_d1;
	logic [2:0] bit_idx_d1;
	logic osd_de_d1;
	logic osd_pixel;

	// ********************
	// stage one
	// ********************

	// window start, half a window before the centre
	assign h_start = h_centre + osd_x_offset - (osd_width >> 1);
	assign v_start = v_centre + osd_y_offset - (osd_height >> 1);
	assign h_rel = h_pos - h_start;
	assign v_rel = v_pos - v_start;

	// unsigned compare also rejects positions before the start
	assign in_window = h_active && v_active && (h_rel < osd_width) && (v_rel < osd_height);

	// row group then column, byte is back next cycle
	assign read_addr = {v_rel[6:4], h_rel[7:0]};

	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			video_d1 <= '0;
			osd_de_d1 <= 1'b0;
			bit_idx_d1 <= 3'd0;
		end else begin
			video_d1 <= video_in;
			osd_de_d1 <= in_window && osd_enable;
			// each bitmap bit covers two lines
			bit_idx_d1 <= v_rel[3:1];
		end
	end

	// ********************
	// stage two
	// ********************

	assign osd_pixel = read_data[bit_idx_d1];

	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			video_out <= '0;
		end else begin
			video_out <= video_d1;
			if (osd_de_d1) begin
				// bit twice, tint bit, then dimmed source
				video_out.red <= {osd_pixel, osd_pixel, osd_color[2], video_d1.red[5:3]};
				video_out.green <= {osd_pixel, osd_pixel, osd_color[1], video_d1.green[5:3]};
				video_out.blue <= {osd_pixel, osd_pixel, osd_color[0], video_d1.blue[5:3]};
			end
		end
	end

endmodule

// File: logic/osd_buffer.sv
/* bitmap store of 2048 bytes, 8 row groups of 256 columns
   written from the command block, read by the mixer with one cycle latency */

`timescale 1ns/1ps

module osd_buffer import osd_ctrl_pkg::*; (
	input  logic                  pclk,
	input  osd_write_t            wr,
	input  logic                  write_valid,
	input  logic [buf_addr_w-1:0] read_addr,
	output logic [7:0]            read_data
);

	// each byte holds 8 vertical bits of one column
	logic [7:0] mem [0:(2**buf_addr_w)-1];

	always_ff @(posedge pclk) begin
		if (write_valid) begin
			mem[wr.addr] <= wr.data;
		end
	end

	// registered read port
	always_ff @(posedge pclk) begin
		read_data <= mem[read_addr];
	end

endmodule

// File: logic/video_timing.sv
/* sync analysis for the incoming video
   counts pixels and lines, finds sync polarity and the centre of the display */

`timescale 1ns/1ps

module video_timing import osd_video_pkg::*; (
	input  logic             pclk,
	input  logic             ss,
	input  video_pixel_t     video_in,
	output logic [pos_w-1:0] h_pos,
	output logic [pos_w-1:0] v_pos,
	output logic [pos_w-1:0] h_centre,
	output logic [pos_w-1:0] v_centre,
	output logic             h_active,
	output logic             v_active
);

	// delayed sync bits
	logic hs_d1, hs_d2;
	logic vs_d1, vs_d2;

	// measured phase lengths
	logic [pos_w-1:0] hs_high, hs_low;
	logic [pos_w-1:0] vs_high, vs_low;

	logic hs_rise, hs_fall;
	logic vs_rise, vs_fall;

	// polarity, set when the high phase is the short sync pulse
	logic hs_pol, vs_pol;
	logic [pos_w-1:0] h_width, v_width;

	assign hs_rise = hs_d1 & ~hs_d2;
	assign hs_fall = ~hs_d1 & hs_d2;
	assign vs_rise = vs_d1 & ~vs_d2;
	assign vs_fall = ~vs_d1 & vs_d2;

	assign hs_pol = hs_high < hs_low;
	assign vs_pol = vs_high < vs_low;

	// the longer phase is the picture
	assign h_width = hs_pol ? hs_low : hs_high;
	assign v_width = vs_pol ? vs_low : vs_high;
	assign h_centre = {1'b0, h_width[pos_w-1:1]};
	assign v_centre = {1'b0, v_width[pos_w-1:1]};

	// phase seen by the counters, not the raw input
	assign h_active = hs_d2 != hs_pol;
	assign v_active = vs_d2 != vs_pol;

	// ********************
	// horizontal
	// ********************

	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			hs_d1 <= 1'b0;
			hs_d2 <= 1'b0;
			h_pos <= '0;
			hs_high <= '0;
			hs_low <= '0;
		end else begin
			hs_d1 <= video_in.hs;
			hs_d2 <= hs_d1;
			if (hs_fall) begin
				// high phase just ended
				h_pos <= '0;
				hs_high <= h_pos + 1'b1;
			end else if (hs_rise) begin
				h_pos <= '0;
				hs_low <= h_pos + 1'b1;
			end else begin
				h_pos <= h_pos + 1'b1;
			end
		end
	end

	// ********************
	// vertical
	// ********************

	// lines are counted on delayed hs rising edges
	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			vs_d1 <= 1'b0;
			vs_d2 <= 1'b0;
			v_pos <= '0;
			vs_high <= '0;
			vs_low <= '0;
		end else begin
			vs_d1 <= video_in.vs;
			vs_d2 <= vs_d1;
			if (vs_fall) begin
				v_pos <= '0;
				vs_high <= v_pos + 1'b1;
			end else if (vs_rise) begin
				v_pos <= '0;
				vs_low <= v_pos + 1'b1;
			end else if (hs_rise) begin
				v_pos <= v_pos + 1'b1;
			end
		end
	end

endmodule

// File: logic/osd_cmd_fsm.sv
/* command decoder for the serial link
   keeps the overlay enable and turns row-write payload into buffer writes */

`timescale 1ns/1ps

module osd_cmd_fsm import osd_ctrl_pkg::*; (
	input  logic       pclk,
	input  logic       ss,
	input  spi_byte_t  rx_byte,
	input  logic       byte_valid,
	output osd_write_t wr,
	output logic       write_valid,
	output logic       osd_enable
);

	typedef enum logic [1:0] {
		st_idle,
		st_write,
		st_ignore
	} state_t;

	state_t state;
	// address of the next payload byte
	logic [buf_addr_w-1:0] addr;

	// ********************
	// command decode
	// ********************

	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			state <= st_idle;
			addr <= '0;
			write_valid <= 1'b0;
			osd_enable <= 1'b0;
		end else begin
			write_valid <= 1'b0;
			if (byte_valid) begin
				if (rx_byte.first) begin
					// command byte, always restarts decoding
					if (rx_byte.data[7:4] == cmd_enable) begin
						osd_enable <= rx_byte.data[0];
						state <= st_idle;
					end else if (rx_byte.data[7:3] == cmd_write) begin
						// row group picks a 256 byte slice
						addr <= {rx_byte.data[2:0], 8'h00};
						state <= st_write;
					end else begin
						state <= st_ignore;
					end
				end else begin
					case (state)
						st_write: begin
							write_valid <= 1'b1;
							// wraps inside the buffer
							addr <= addr + 1'b1;
						end
						// trailing bytes of enable or unknown commands
						st_idle,
						st_ignore: ;
						default: state <= st_idle;
					endcase
				end
			end
		end
	end

	// write payload follows the strobe by one cycle
	always_ff @(posedge pclk) begin
		if (byte_valid && !rx_byte.first && state == st_write) begin
			wr.addr <= addr;
			wr.data <= rx_byte.data;
		end
	end

endmodule

// File: logic/spi_deserializer.sv
/* serial receiver running on the pixel clock
   oversamples sck, cs_n and sdi and delivers whole bytes with a first-byte flag */

`timescale 1ns/1ps

module spi_deserializer import osd_ctrl_pkg::*; (
	input  logic      pclk,
	input  logic      ss,
	input  logic      sck,
	input  logic      cs_n,
	input  logic      sdi,
	output spi_byte_t rx_byte,
	output logic      byte_valid
);

	// two flop synchronizers, index 1 is the stable copy
	logic [1:0] sck_sync;
	logic [1:0] cs_n_sync;
	logic [1:0] sdi_sync;
	// previous synchronized sck for edge detect
	logic sck_d;
	logic sck_rise;

	logic [7:0] shift_reg;
	logic [2:0] bit_cnt;
	// next complete byte opens a new transfer
	logic first_pending;

	assign sck_rise = sck_sync[1] & ~sck_d;

	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			sck_sync <= 2'b00;
			cs_n_sync <= 2'b11;
			sdi_sync <= 2'b00;
			sck_d <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[0], sck};
			cs_n_sync <= {cs_n_sync[0], cs_n};
			sdi_sync <= {sdi_sync[0], sdi};
			sck_d <= sck_sync[1];
		end
	end

	// byte framing, msb first
	always_ff @(posedge pclk or posedge ss) begin
		if (ss) begin
			bit_cnt <= 3'd0;
			first_pending <= 1'b1;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			if (cs_n_sync[1]) begin
				// deselected, drop any partial byte
				bit_cnt <= 3'd0;
				first_pending <= 1'b1;
			end else if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (bit_cnt == 3'd7) begin
					byte_valid <= 1'b1;
					first_pending <= 1'b0;
				end
			end
		end
	end

	// payload path, no reset needed
	always_ff @(posedge pclk) begin
		if (!cs_n_sync[1] && sck_rise) begin
			shift_reg <= {shift_reg[6:0], sdi_sync[1]};
			if (bit_cnt == 3'd7) begin
				rx_byte.data <= {shift_reg[6:0], sdi_sync[1]};
				rx_byte.first <= first_pending;
			end
		end
	end

endmodule

// File: logic/osd_ctrl_pkg.sv
/* control side definitions, serial bytes, command codes and buffer writes
   imported by the serial, command and buffer blocks */

package osd_ctrl_pkg;

	// bitmap memory address width, 2048 bytes
	localparam int buf_addr_w = 11;

	// byte from the serial link
	typedef struct packed {
		logic [7:0] data;
		// set on the first byte after select goes low
		logic first;
	} spi_byte_t;

	// one write into the bitmap memory
	typedef struct packed {
		logic [buf_addr_w-1:0] addr;
		logic [7:0] data;
	} osd_write_t;

	// ********************
	// command codes
	// ********************

	// upper nibble of enable/disable, low bit carries the new state
	localparam logic [3:0] cmd_enable = 4'b0100;
	// upper five bits of row write, low three bits pick the row group
	localparam logic [4:0] cmd_write = 5'b00100;

endpackage

// File: logic/osd_video_pkg.sv
/* video side definitions for the on-screen display
   imported by the timing, mixer and top level blocks */

package osd_video_pkg;

	// ********************
	// widths
	// ********************

	// bits per colour channel
	localparam int color_w = 6;
	// horizontal and vertical counter width
	localparam int pos_w = 10;

	// one pixel as it travels from core to connector
	typedef struct packed {
		logic [color_w-1:0] red;
		logic [color_w-1:0] green;
		logic [color_w-1:0] blue;
		logic hs;
		logic vs;
	} video_pixel_t;

	// ********************
	// overlay window
	// ********************

	// window size in pixels and lines
	localparam logic [pos_w-1:0] osd_width = 10'd256;
	localparam logic [pos_w-1:0] osd_height = 10'd128;

	// shift of the window away from the display centre
	localparam logic [pos_w-1:0] osd_x_offset = 10'd0;
	localparam logic [pos_w-1:0] osd_y_offset = 10'd0;

	// overlay tint, red green blue from msb down
	localparam logic [2:0] osd_color = 3'd1;

endpackage
